// ==== core_pkg.sv ====
// shared definitions for the out-of-order integer core
// widths, depths, RV32I opcode fields, ALU op codes and the instruction word
package core_pkg;

	////////////////////////////////////////////////////////////////////////////
	// widths and depths
	////////////////////////////////////////////////////////////////////////////

	localparam int XLEN      = 32;
	localparam int REG_IDX_W = 5;
	localparam int NUM_REGS  = 32;

	// reorder buffer, depth must be a power of two
	localparam int ROB_DEPTH = 8;
	localparam int ROB_TAG_W = 3;

	// reservation station, index width also sizes the age rank
	localparam int RS_DEPTH  = 4;
	localparam int RS_IDX_W  = 2;

	////////////////////////////////////////////////////////////////////////////
	// RV32I encodings
	////////////////////////////////////////////////////////////////////////////

	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

	// funct3 values of the kept ALU instructions
	localparam logic [2:0] F3_ADD_SUB = 3'b000;
	localparam logic [2:0] F3_SLL     = 3'b001;
	localparam logic [2:0] F3_SLT     = 3'b010;
	localparam logic [2:0] F3_XOR     = 3'b100;
	localparam logic [2:0] F3_SRL     = 3'b101;
	localparam logic [2:0] F3_OR      = 3'b110;
	localparam logic [2:0] F3_AND     = 3'b111;

	// funct7, only sub uses the alternate value
	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_SUB  = 7'b0100000;

	// ALU op codes
	localparam int ALU_OP_W = 3;
	localparam logic [ALU_OP_W-1:0] ALU_ADD = 3'd0;
	localparam logic [ALU_OP_W-1:0] ALU_SUB = 3'd1;
	localparam logic [ALU_OP_W-1:0] ALU_AND = 3'd2;
	localparam logic [ALU_OP_W-1:0] ALU_OR  = 3'd3;
	localparam logic [ALU_OP_W-1:0] ALU_XOR = 3'd4;
	localparam logic [ALU_OP_W-1:0] ALU_SLT = 3'd5;
	localparam logic [ALU_OP_W-1:0] ALU_SLL = 3'd6;
	localparam logic [ALU_OP_W-1:0] ALU_SRL = 3'd7;

	// one instruction word, seen as R-type or as I-type fields
	typedef union packed {
		struct packed {
			logic [6:0]           funct7;
			logic [REG_IDX_W-1:0] rs2;
			logic [REG_IDX_W-1:0] rs1;
			logic [2:0]           funct3;
			logic [REG_IDX_W-1:0] rd;
			logic [6:0]           opcode;
		} r;
		struct packed {
			logic [11:0]          imm12;
			logic [REG_IDX_W-1:0] rs1;
			logic [2:0]           funct3;
			logic [REG_IDX_W-1:0] rd;
			logic [6:0]           opcode;
		} i;
	} inst_word_t;

endpackage

// ==== issue_decode.sv ====
// issue stage: decodes ALU instructions, renames sources through the map table
// and reads operands from the register file or the reorder buffer
`timescale 1ns/100ps

module issue_decode
	import core_pkg::*;
(
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 inst_valid,
	input  inst_word_t           inst,
	input  logic                 rob_full,
	input  logic                 station_full,
	input  logic [ROB_TAG_W-1:0] alloc_tag,
	input  logic                 read_ready1,
	input  logic [XLEN-1:0]      read_value1,
	input  logic                 read_ready2,
	input  logic [XLEN-1:0]      read_value2,
	input  logic                 commit_valid,
	input  logic                 commit_wr_en,
	input  logic [REG_IDX_W-1:0] commit_wr_idx,
	input  logic [XLEN-1:0]      commit_wr_data,
	input  logic [ROB_TAG_W-1:0] commit_tag,
	output logic                 issue_stall,
	output logic                 issue_fire,
	output logic [ALU_OP_W-1:0]  issue_op,
	output logic                 issue_src1_ready,
	output logic [XLEN-1:0]      issue_src1_value,
	output logic [ROB_TAG_W-1:0] issue_src1_tag,
	output logic                 issue_src2_ready,
	output logic [XLEN-1:0]      issue_src2_value,
	output logic [ROB_TAG_W-1:0] issue_src2_tag,
	output logic                 issue_wr_en,
	output logic [REG_IDX_W-1:0] issue_rd,
	output logic [ROB_TAG_W-1:0] read_tag1,
	output logic [ROB_TAG_W-1:0] read_tag2
);

	// architectural state and rename map
	logic [XLEN-1:0]      regs [NUM_REGS];
	logic [NUM_REGS-1:0]  map_valid;
	logic [ROB_TAG_W-1:0] map_tag [NUM_REGS];

	logic                 supported;
	logic                 is_imm;
	logic [REG_IDX_W-1:0] rs1_idx;
	logic [REG_IDX_W-1:0] rs2_idx;
	logic [XLEN-1:0]      rf_val1;
	logic [XLEN-1:0]      rf_val2;
	logic [XLEN-1:0]      imm_sext;

	// stall is a pure function of state
	assign issue_stall = rob_full | station_full;
	assign issue_fire  = inst_valid & ~issue_stall;

	assign rs1_idx  = inst.r.rs1;
	assign rs2_idx  = inst.r.rs2;
	assign issue_rd = inst.r.rd;
	assign is_imm   = (inst.i.opcode == OPC_OP_IMM);
	assign imm_sext = {{(XLEN-12){inst.i.imm12[11]}}, inst.i.imm12};

	// x0 always reads zero
	assign rf_val1 = (rs1_idx == '0) ? '0 : regs[rs1_idx];
	assign rf_val2 = (rs2_idx == '0) ? '0 : regs[rs2_idx];

	assign read_tag1 = map_tag[rs1_idx];
	assign read_tag2 = map_tag[rs2_idx];

	////////////////////////////////////////////////////////////////////////////
	// decode
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		issue_op  = ALU_ADD;
		supported = 1'b0;
		if (inst.r.opcode == OPC_OP) begin
			// register form, funct7 must be the base value except for sub
			supported = (inst.r.funct7 == F7_BASE);
			case (inst.r.funct3)
				F3_ADD_SUB: begin
					issue_op  = (inst.r.funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
					supported = (inst.r.funct7 == F7_BASE) || (inst.r.funct7 == F7_SUB);
				end
				F3_SLL:  issue_op = ALU_SLL;
				F3_SLT:  issue_op = ALU_SLT;
				F3_XOR:  issue_op = ALU_XOR;
				F3_SRL:  issue_op = ALU_SRL;
				F3_OR:   issue_op = ALU_OR;
				F3_AND:  issue_op = ALU_AND;
				default: supported = 1'b0;
			endcase
		end else if (is_imm) begin
			// immediate form, no shifts kept
			supported = 1'b1;
			case (inst.i.funct3)
				F3_ADD_SUB: issue_op = ALU_ADD;
				F3_SLT:     issue_op = ALU_SLT;
				F3_XOR:     issue_op = ALU_XOR;
				F3_OR:      issue_op = ALU_OR;
				F3_AND:     issue_op = ALU_AND;
				default:    supported = 1'b0;
			endcase
		end
	end

	// unsupported ops still retire, just with no write
	assign issue_wr_en = supported && (issue_rd != '0);

	////////////////////////////////////////////////////////////////////////////
	// operand selection
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		issue_src1_ready = 1'b1;
		issue_src1_value = rf_val1;
		issue_src1_tag   = map_tag[rs1_idx];
		issue_src2_ready = 1'b1;
		issue_src2_value = rf_val2;
		issue_src2_tag   = map_tag[rs2_idx];
		if (!supported) begin
			// zero operands, never wait on a tag
			issue_src1_value = '0;
			issue_src2_value = '0;
		end else begin
			if (map_valid[rs1_idx]) begin
				issue_src1_ready = read_ready1;
				issue_src1_value = read_value1;
			end
			if (is_imm) begin
				issue_src2_value = imm_sext;
			end else if (map_valid[rs2_idx]) begin
				issue_src2_ready = read_ready2;
				issue_src2_value = read_value2;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// register file and map table
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int k = 0; k < NUM_REGS; k++) begin
				regs[k] <= '0;
			end
		end else if (commit_valid && commit_wr_en && (commit_wr_idx != '0)) begin
			regs[commit_wr_idx] <= commit_wr_data;
		end
	end

	// a new mapping beats a commit clear on the same register
	always_ff @(posedge clock) begin
		if (reset) begin
			map_valid <= '0;
		end else begin
			for (int k = 0; k < NUM_REGS; k++) begin
				if (issue_fire && issue_wr_en && (issue_rd == REG_IDX_W'(k))) begin
					map_valid[k] <= 1'b1;
				end else if (commit_valid && commit_wr_en &&
						(commit_wr_idx == REG_IDX_W'(k)) && (map_tag[k] == commit_tag)) begin
					map_valid[k] <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (issue_fire && issue_wr_en) begin
			map_tag[issue_rd] <= alloc_tag;
		end
	end

endmodule

// ==== alu_station.sv ====
// ALU reservation station with result bus snooping, oldest-ready dispatch
// and a registered common data bus output
`timescale 1ns/100ps

module alu_station
	import core_pkg::*;
(
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 issue_fire,
	input  logic [ALU_OP_W-1:0]  issue_op,
	input  logic                 issue_src1_ready,
	input  logic [XLEN-1:0]      issue_src1_value,
	input  logic [ROB_TAG_W-1:0] issue_src1_tag,
	input  logic                 issue_src2_ready,
	input  logic [XLEN-1:0]      issue_src2_value,
	input  logic [ROB_TAG_W-1:0] issue_src2_tag,
	input  logic [ROB_TAG_W-1:0] alloc_tag,
	output logic                 station_full,
	output logic                 cdb_valid,
	output logic [ROB_TAG_W-1:0] cdb_tag,
	output logic [XLEN-1:0]      cdb_value
);

	// entry control
	logic [RS_DEPTH-1:0]  busy;
	logic [RS_DEPTH-1:0]  rdy1;
	logic [RS_DEPTH-1:0]  rdy2;
	// age counts the younger busy entries, so the oldest has the largest
	logic [RS_IDX_W-1:0]  age [RS_DEPTH];

	// entry payload
	logic [ALU_OP_W-1:0]  op   [RS_DEPTH];
	logic [ROB_TAG_W-1:0] dst  [RS_DEPTH];
	logic [ROB_TAG_W-1:0] tag1 [RS_DEPTH];
	logic [ROB_TAG_W-1:0] tag2 [RS_DEPTH];
	logic [XLEN-1:0]      val1 [RS_DEPTH];
	logic [XLEN-1:0]      val2 [RS_DEPTH];

	logic [RS_IDX_W-1:0]  free_idx;
	logic [RS_IDX_W-1:0]  sel_idx;
	logic [RS_IDX_W-1:0]  sel_age;
	logic                 sel_valid;
	logic [XLEN-1:0]      alu_a;
	logic [XLEN-1:0]      alu_b;
	logic [XLEN-1:0]      alu_result;

	assign station_full = &busy;

	// lowest free entry
	always_comb begin
		free_idx = '0;
		for (int k = RS_DEPTH - 1; k >= 0; k--) begin
			if (!busy[k]) begin
				free_idx = RS_IDX_W'(k);
			end
		end
	end

	// oldest entry with both operands in hand
	always_comb begin
		sel_valid = 1'b0;
		sel_idx   = '0;
		sel_age   = '0;
		for (int k = 0; k < RS_DEPTH; k++) begin
			if (busy[k] && rdy1[k] && rdy2[k] && (!sel_valid || (age[k] > sel_age))) begin
				sel_valid = 1'b1;
				sel_idx   = RS_IDX_W'(k);
				sel_age   = age[k];
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// entry update
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			busy <= '0;
			rdy1 <= '0;
			rdy2 <= '0;
			for (int k = 0; k < RS_DEPTH; k++) begin
				age[k] <= '0;
			end
		end else begin
			for (int k = 0; k < RS_DEPTH; k++) begin
				// dispatched entry leaves
				if (sel_valid && (sel_idx == RS_IDX_W'(k))) begin
					busy[k] <= 1'b0;
				end
				if (issue_fire && (free_idx == RS_IDX_W'(k))) begin
					busy[k] <= 1'b1;
					rdy1[k] <= issue_src1_ready;
					rdy2[k] <= issue_src2_ready;
					age[k]  <= '0;
				end else if (busy[k]) begin
					// wake up on a matching broadcast
					if (!rdy1[k] && cdb_valid && (tag1[k] == cdb_tag)) begin
						rdy1[k] <= 1'b1;
					end
					if (!rdy2[k] && cdb_valid && (tag2[k] == cdb_tag)) begin
						rdy2[k] <= 1'b1;
					end
					// one younger arrives, or a younger one leaves
					if (issue_fire && !(sel_valid && (age[k] > sel_age))) begin
						age[k] <= age[k] + 1'b1;
					end else if (!issue_fire && sel_valid && (age[k] > sel_age)) begin
						age[k] <= age[k] - 1'b1;
					end
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		for (int k = 0; k < RS_DEPTH; k++) begin
			if (issue_fire && (free_idx == RS_IDX_W'(k))) begin
				op[k]   <= issue_op;
				dst[k]  <= alloc_tag;
				tag1[k] <= issue_src1_tag;
				tag2[k] <= issue_src2_tag;
				val1[k] <= issue_src1_value;
				val2[k] <= issue_src2_value;
			end else begin
				if (!rdy1[k] && cdb_valid && (tag1[k] == cdb_tag)) begin
					val1[k] <= cdb_value;
				end
				if (!rdy2[k] && cdb_valid && (tag2[k] == cdb_tag)) begin
					val2[k] <= cdb_value;
				end
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// ALU and bus register
	////////////////////////////////////////////////////////////////////////////

	assign alu_a = val1[sel_idx];
	assign alu_b = val2[sel_idx];

	always_comb begin
		case (op[sel_idx])
			ALU_ADD: alu_result = alu_a + alu_b;
			ALU_SUB: alu_result = alu_a - alu_b;
			ALU_AND: alu_result = alu_a & alu_b;
			ALU_OR:  alu_result = alu_a | alu_b;
			ALU_XOR: alu_result = alu_a ^ alu_b;
			ALU_SLT: alu_result = {{(XLEN-1){1'b0}}, $signed(alu_a) < $signed(alu_b)};
			// shift amount from the low bits only
			ALU_SLL: alu_result = alu_a << alu_b[$clog2(XLEN)-1:0];
			default: alu_result = alu_a >> alu_b[$clog2(XLEN)-1:0];
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			cdb_valid <= 1'b0;
		end else begin
			cdb_valid <= sel_valid;
		end
	end

	always_ff @(posedge clock) begin
		if (sel_valid) begin
			cdb_tag   <= dst[sel_idx];
			cdb_value <= alu_result;
		end
	end

endmodule

// ==== reorder_buffer.sv ====
// reorder buffer: in-order slot allocation, result capture from the bus,
// operand read ports with bus forwarding and in-order commit
`timescale 1ns/100ps

module reorder_buffer
	import core_pkg::*;
(
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 issue_fire,
	input  logic                 issue_wr_en,
	input  logic [REG_IDX_W-1:0] issue_rd,
	input  logic [ROB_TAG_W-1:0] read_tag1,
	input  logic [ROB_TAG_W-1:0] read_tag2,
	input  logic                 cdb_valid,
	input  logic [ROB_TAG_W-1:0] cdb_tag,
	input  logic [XLEN-1:0]      cdb_value,
	output logic [ROB_TAG_W-1:0] alloc_tag,
	output logic                 rob_full,
	output logic                 read_ready1,
	output logic [XLEN-1:0]      read_value1,
	output logic                 read_ready2,
	output logic [XLEN-1:0]      read_value2,
	output logic                 commit_valid,
	output logic                 commit_wr_en,
	output logic [REG_IDX_W-1:0] commit_wr_idx,
	output logic [XLEN-1:0]      commit_wr_data,
	output logic [ROB_TAG_W-1:0] commit_tag
);

	// slot storage
	logic [REG_IDX_W-1:0] slot_rd    [ROB_DEPTH];
	logic [XLEN-1:0]      slot_value [ROB_DEPTH];
	logic [ROB_DEPTH-1:0] slot_wr_en;
	logic [ROB_DEPTH-1:0] slot_ready;

	// circular pointers, wrap is free since depth is a power of two
	logic [ROB_TAG_W-1:0] head;
	logic [ROB_TAG_W-1:0] tail;
	logic [ROB_TAG_W:0]   count;

	logic hit1;
	logic hit2;

	assign alloc_tag = tail;
	assign rob_full  = (count == (ROB_TAG_W+1)'(ROB_DEPTH));

	////////////////////////////////////////////////////////////////////////////
	// read ports
	////////////////////////////////////////////////////////////////////////////

	// forward a result broadcast this cycle
	assign hit1 = cdb_valid && (cdb_tag == read_tag1);
	assign hit2 = cdb_valid && (cdb_tag == read_tag2);

	assign read_ready1 = slot_ready[read_tag1] | hit1;
	assign read_value1 = hit1 ? cdb_value : slot_value[read_tag1];
	assign read_ready2 = slot_ready[read_tag2] | hit2;
	assign read_value2 = hit2 ? cdb_value : slot_value[read_tag2];

	////////////////////////////////////////////////////////////////////////////
	// head commit
	////////////////////////////////////////////////////////////////////////////

	assign commit_valid   = (count != '0) && slot_ready[head];
	assign commit_wr_en   = slot_wr_en[head];
	assign commit_wr_idx  = slot_rd[head];
	assign commit_wr_data = slot_value[head];
	assign commit_tag     = head;

	always_ff @(posedge clock) begin
		if (reset) begin
			head       <= '0;
			tail       <= '0;
			count      <= '0;
			slot_ready <= '0;
		end else begin
			if (issue_fire) begin
				tail             <= tail + 1'b1;
				slot_ready[tail] <= 1'b0;
			end
			if (cdb_valid) begin
				slot_ready[cdb_tag] <= 1'b1;
			end
			if (commit_valid) begin
				head <= head + 1'b1;
			end
			case ({issue_fire, commit_valid})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// payload, written at allocation and on the bus
	always_ff @(posedge clock) begin
		if (issue_fire) begin
			slot_rd[tail]    <= issue_rd;
			slot_wr_en[tail] <= issue_wr_en;
		end
		if (cdb_valid) begin
			slot_value[cdb_tag] <= cdb_value;
		end
	end

endmodule

// ==== tomasulo_core.sv ====
// out-of-order RV32I integer core, top level
// connects issue decode, the ALU station and the reorder buffer
`timescale 1ns/100ps

module tomasulo_core
	import core_pkg::*;
(
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 inst_valid,
	input  inst_word_t           inst,
	output logic                 issue_stall,
	output logic                 commit_valid,
	output logic                 commit_wr_en,
	output logic [REG_IDX_W-1:0] commit_wr_idx,
	output logic [XLEN-1:0]      commit_wr_data
);

	// issue to station and reorder buffer
	logic                 issue_fire;
	logic [ALU_OP_W-1:0]  issue_op;
	logic                 issue_src1_ready;
	logic [XLEN-1:0]      issue_src1_value;
	logic [ROB_TAG_W-1:0] issue_src1_tag;
	logic                 issue_src2_ready;
	logic [XLEN-1:0]      issue_src2_value;
	logic [ROB_TAG_W-1:0] issue_src2_tag;
	logic                 issue_wr_en;
	logic [REG_IDX_W-1:0] issue_rd;

	// reorder buffer status and read ports
	logic [ROB_TAG_W-1:0] alloc_tag;
	logic                 rob_full;
	logic                 station_full;
	logic [ROB_TAG_W-1:0] read_tag1;
	logic [ROB_TAG_W-1:0] read_tag2;
	logic                 read_ready1;
	logic [XLEN-1:0]      read_value1;
	logic                 read_ready2;
	logic [XLEN-1:0]      read_value2;

	// result bus and commit tag
	logic                 cdb_valid;
	logic [ROB_TAG_W-1:0] cdb_tag;
	logic [XLEN-1:0]      cdb_value;
	logic [ROB_TAG_W-1:0] commit_tag;

	////////////////////////////////////////////////////////////////////////////
	// issue
	////////////////////////////////////////////////////////////////////////////

	issue_decode issue_decode_0 (
		.clock            (clock),
		.reset            (reset),
		.inst_valid       (inst_valid),
		.inst             (inst),
		.rob_full         (rob_full),
		.station_full     (station_full),
		.alloc_tag        (alloc_tag),
		.read_ready1      (read_ready1),
		.read_value1      (read_value1),
		.read_ready2      (read_ready2),
		.read_value2      (read_value2),
		.commit_valid     (commit_valid),
		.commit_wr_en     (commit_wr_en),
		.commit_wr_idx    (commit_wr_idx),
		.commit_wr_data   (commit_wr_data),
		.commit_tag       (commit_tag),
		.issue_stall      (issue_stall),
		.issue_fire       (issue_fire),
		.issue_op         (issue_op),
		.issue_src1_ready (issue_src1_ready),
		.issue_src1_value (issue_src1_value),
		.issue_src1_tag   (issue_src1_tag),
		.issue_src2_ready (issue_src2_ready),
		.issue_src2_value (issue_src2_value),
		.issue_src2_tag   (issue_src2_tag),
		.issue_wr_en      (issue_wr_en),
		.issue_rd         (issue_rd),
		.read_tag1        (read_tag1),
		.read_tag2        (read_tag2)
	);

	////////////////////////////////////////////////////////////////////////////
	// execute
	////////////////////////////////////////////////////////////////////////////

	alu_station alu_station_0 (
		.clock            (clock),
		.reset            (reset),
		.issue_fire       (issue_fire),
		.issue_op         (issue_op),
		.issue_src1_ready (issue_src1_ready),
		.issue_src1_value (issue_src1_value),
		.issue_src1_tag   (issue_src1_tag),
		.issue_src2_ready (issue_src2_ready),
		.issue_src2_value (issue_src2_value),
		.issue_src2_tag   (issue_src2_tag),
		.alloc_tag        (alloc_tag),
		.station_full     (station_full),
		.cdb_valid        (cdb_valid),
		.cdb_tag          (cdb_tag),
		.cdb_value        (cdb_value)
	);

	////////////////////////////////////////////////////////////////////////////
	// result and commit
	////////////////////////////////////////////////////////////////////////////

	reorder_buffer reorder_buffer_0 (
		.clock          (clock),
		.reset          (reset),
		.issue_fire     (issue_fire),
		.issue_wr_en    (issue_wr_en),
		.issue_rd       (issue_rd),
		.read_tag1      (read_tag1),
		.read_tag2      (read_tag2),
		.cdb_valid      (cdb_valid),
		.cdb_tag        (cdb_tag),
		.cdb_value      (cdb_value),
		.alloc_tag      (alloc_tag),
		.rob_full       (rob_full),
		.read_ready1    (read_ready1),
		.read_value1    (read_value1),
		.read_ready2    (read_ready2),
		.read_value2    (read_value2),
		.commit_valid   (commit_valid),
		.commit_wr_en   (commit_wr_en),
		.commit_wr_idx  (commit_wr_idx),
		.commit_wr_data (commit_wr_data),
		.commit_tag     (commit_tag)
	);

endmodule

// ==== tb_tomasulo_core.sv ====
// testbench for the out-of-order integer core
// LFSR driven ALU instructions, checked at commit against a register model
`timescale 1ns/100ps

module tb_tomasulo_core
	import core_pkg::*;
();

	localparam int STALL_LIMIT = 200;
	localparam int DRAIN_LIMIT = 500;

	logic                 clock;
	logic                 reset;
	logic                 inst_valid;
	inst_word_t           inst;
	logic                 issue_stall;
	logic                 commit_valid;
	logic                 commit_wr_en;
	logic [REG_IDX_W-1:0] commit_wr_idx;
	logic [XLEN-1:0]      commit_wr_data;

	// architectural model, updated in program order at send time
	logic [XLEN-1:0]      model_regs [NUM_REGS];

	// expected commits, oldest first
	logic                 exp_wr_en [$];
	logic [REG_IDX_W-1:0] exp_idx [$];
	logic [XLEN-1:0]      exp_data [$];

	logic [31:0]          lfsr_state;
	logic                 stall_seen;
	logic                 timed_out;
	int                   error_count;
	int                   errors_at_start;
	int                   issue_count;
	int                   commit_count;
	int                   tests_run;
	int                   tests_failed;

	tomasulo_core UUT (
		.clock          (clock),
		.reset          (reset),
		.inst_valid     (inst_valid),
		.inst           (inst),
		.issue_stall    (issue_stall),
		.commit_valid   (commit_valid),
		.commit_wr_en   (commit_wr_en),
		.commit_wr_idx  (commit_wr_idx),
		.commit_wr_data (commit_wr_data)
	);

	initial clock = 1'b0;
	always #50 clock = ~clock;

	////////////////////////////////////////////////////////////////////////////
	// random source and reference model
	////////////////////////////////////////////////////////////////////////////

	// taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int k = 0; k < n; k++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	// kept subset only, rd of zero never writes
	function automatic logic writes_reg(input inst_word_t w);
		logic known;
		known = 1'b0;
		if (w.r.opcode == OPC_OP) begin
			// sltu is not kept
			known = ((w.r.funct7 == F7_BASE) && (w.r.funct3 != 3'b011)) ||
				((w.r.funct7 == F7_SUB) && (w.r.funct3 == F3_ADD_SUB));
		end else if (w.i.opcode == OPC_OP_IMM) begin
			// no immediate shifts and no sltiu
			known = (w.i.funct3 != F3_SLL) && (w.i.funct3 != F3_SRL) &&
				(w.i.funct3 != 3'b011);
		end
		return known && (w.r.rd != '0);
	endfunction

	function automatic logic [XLEN-1:0] alu_ref(input inst_word_t w);
		logic [XLEN-1:0] a;
		logic [XLEN-1:0] b;
		logic [XLEN-1:0] y;
		a = model_regs[w.r.rs1];
		if (w.i.opcode == OPC_OP_IMM) begin
			b = {{(XLEN-12){w.i.imm12[11]}}, w.i.imm12};
		end else begin
			b = model_regs[w.r.rs2];
		end
		case (w.r.funct3)
			F3_ADD_SUB: y = ((w.r.opcode == OPC_OP) && (w.r.funct7 == F7_SUB)) ? a - b : a + b;
			F3_SLL:     y = a << b[4:0];
			F3_SLT:     y = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			F3_XOR:     y = a ^ b;
			F3_SRL:     y = a >> b[4:0];
			F3_OR:      y = a | b;
			default:    y = a & b;
		endcase
		return y;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// instruction builders
	////////////////////////////////////////////////////////////////////////////

	function automatic inst_word_t make_reg_op(input logic [2:0] sel, input logic [4:0] rd,
			input logic [4:0] rs1, input logic [4:0] rs2);
		inst_word_t w;
		w.r.opcode = OPC_OP;
		w.r.rd     = rd;
		w.r.rs1    = rs1;
		w.r.rs2    = rs2;
		w.r.funct7 = F7_BASE;
		case (sel)
			3'd0: w.r.funct3 = F3_ADD_SUB;
			3'd1: begin
				w.r.funct3 = F3_ADD_SUB;
				w.r.funct7 = F7_SUB;
			end
			3'd2: w.r.funct3 = F3_AND;
			3'd3: w.r.funct3 = F3_OR;
			3'd4: w.r.funct3 = F3_XOR;
			3'd5: w.r.funct3 = F3_SLT;
			3'd6: w.r.funct3 = F3_SLL;
			default: w.r.funct3 = F3_SRL;
		endcase
		return w;
	endfunction

	// addi andi ori xori slti, spare codes fold back
	function automatic inst_word_t make_imm_op(input logic [2:0] sel, input logic [4:0] rd,
			input logic [4:0] rs1, input logic [11:0] imm);
		inst_word_t w;
		w.i.opcode = OPC_OP_IMM;
		w.i.rd     = rd;
		w.i.rs1    = rs1;
		w.i.imm12  = imm;
		case (sel)
			3'd1, 3'd5: w.i.funct3 = F3_AND;
			3'd2:       w.i.funct3 = F3_OR;
			3'd3, 3'd6: w.i.funct3 = F3_XOR;
			3'd4, 3'd7: w.i.funct3 = F3_SLT;
			default:    w.i.funct3 = F3_ADD_SUB;
		endcase
		return w;
	endfunction

	function automatic inst_word_t random_op(input logic [4:0] rs1);
		logic        form;
		logic [2:0]  sel;
		logic [4:0]  rd;
		logic [4:0]  rs2;
		logic [11:0] imm;
		form = 1'(rand_bits(1));
		sel  = 3'(rand_bits(3));
		rd   = 5'(rand_bits(5));
		rs2  = 5'(rand_bits(5));
		imm  = 12'(rand_bits(12));
		return form ? make_imm_op(sel, rd, rs1, imm) : make_reg_op(sel, rd, rs1, rs2);
	endfunction

	// both sources from the previous result, nonzero rd keeps the chain alive
	function automatic inst_word_t chain_op(input logic [4:0] src);
		inst_word_t w;
		logic [4:0] rd;
		w  = random_op(src);
		rd = 5'(rand_bits(5));
		w.r.rd = (rd == '0) ? 5'd1 : rd;
		if (w.r.opcode == OPC_OP) begin
			w.r.rs2 = src;
		end
		return w;
	endfunction

	// opcodes outside the kept set
	function automatic logic [6:0] other_opcode(input logic [2:0] sel);
		case (sel)
			3'd0, 3'd6: return 7'b0000011;
			3'd1, 3'd7: return 7'b0100011;
			3'd2:       return 7'b1100011;
			3'd3:       return 7'b0110111;
			3'd4:       return 7'b1101111;
			default:    return 7'b1110011;
		endcase
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////////////////////

	task automatic check_word(input string name, input logic [XLEN-1:0] got,
			input logic [XLEN-1:0] exp);
		if (got !== exp) begin
			$display("ERROR %s got %h expected %h", name, got, exp);
			error_count++;
		end
	endtask

	task automatic check_idx(input string name, input logic [REG_IDX_W-1:0] got,
			input logic [REG_IDX_W-1:0] exp);
		if (got !== exp) begin
			$display("ERROR %s got %h expected %h", name, got, exp);
			error_count++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("ERROR %s got %h expected %h", name, got, exp);
			error_count++;
		end
	endtask

	// commit outputs only change at the rising edge
	always @(negedge clock) begin
		logic                 e_wr;
		logic [REG_IDX_W-1:0] e_idx;
		logic [XLEN-1:0]      e_data;
		if (!reset && commit_valid) begin
			commit_count++;
			if (exp_data.size() == 0) begin
				$display("commit seen with no instruction pending");
				error_count++;
			end else begin
				e_wr   = exp_wr_en.pop_front();
				e_idx  = exp_idx.pop_front();
				e_data = exp_data.pop_front();
				check_bit("commit_wr_en", commit_wr_en, e_wr);
				if (e_wr) begin
					check_idx("commit_wr_idx", commit_wr_idx, e_idx);
					check_word("commit_wr_data", commit_wr_data, e_data);
				end
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// sender and test control
	////////////////////////////////////////////////////////////////////////////

	// later steps fall through once a wait has run out
	task automatic report_timeout(input string why);
		$display("timeout: %s", why);
		timed_out = 1'b1;
		error_count++;
	endtask

	// called at a falling edge, returns at the falling edge after acceptance
	task automatic issue_inst(input inst_word_t w);
		logic wr;
		int   waited;
		if (!timed_out) begin
			wr = writes_reg(w);
			exp_wr_en.push_back(wr);
			exp_idx.push_back(w.r.rd);
			exp_data.push_back(alu_ref(w));
			if (wr) begin
				model_regs[w.r.rd] = alu_ref(w);
			end
			inst_valid = 1'b1;
			inst       = w;
			waited     = 0;
			// stall is state only, so it is settled here
			while (issue_stall && (waited < STALL_LIMIT)) begin
				stall_seen = 1'b1;
				@(negedge clock);
				waited++;
			end
			if (issue_stall) begin
				inst_valid = 1'b0;
				report_timeout("issue_stall stayed high, instruction never accepted");
			end else begin
				@(negedge clock);
				inst_valid = 1'b0;
				issue_count++;
			end
		end
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		if (!timed_out) begin
			while ((exp_data.size() != 0) && (waited < DRAIN_LIMIT)) begin
				@(negedge clock);
				waited++;
			end
			if (exp_data.size() != 0) begin
				report_timeout("commits stopped with results still pending");
			end
		end
	endtask

	task automatic end_test(input string name);
		int    errs;
		string verdict;
		wait_drain();
		errs = error_count - errors_at_start;
		tests_run++;
		verdict = "ok";
		if ((errs != 0) || timed_out) begin
			tests_failed++;
			verdict = "FAIL";
		end
		$display("test %s: %s (%0d errors)", name, verdict, errs);
		errors_at_start = error_count;
	endtask

	initial begin
		inst_word_t w;
		logic [4:0] prev_rd;
		int         issued_before;
		int         committed_before;
		lfsr_state      = 32'hd3c3b302;
		stall_seen      = 1'b0;
		timed_out       = 1'b0;
		error_count     = 0;
		errors_at_start = 0;
		issue_count     = 0;
		commit_count    = 0;
		tests_run       = 0;
		tests_failed    = 0;
		for (int k = 0; k < NUM_REGS; k++) begin
			model_regs[k] = '0;
		end
		reset      = 1'b1;
		inst_valid = 1'b0;
		inst       = '0;
		repeat (10) @(negedge clock);
		reset = 1'b0;
		@(negedge clock);

		// quiet outputs, then reads of untouched registers
		check_bit("issue_stall", issue_stall, 1'b0);
		check_bit("commit_valid", commit_valid, 1'b0);
		issue_inst(make_imm_op(3'd0, 5'd1, 5'd0, 12'h005));
		issue_inst(make_reg_op(3'd0, 5'd2, 5'd3, 5'd4));
		issue_inst(make_reg_op(3'd1, 5'd3, 5'd0, 5'd1));
		issue_inst(make_imm_op(3'd4, 5'd4, 5'd3, 12'hfff));
		end_test("reset");

		for (int n = 0; n < 40; n++) begin
			issue_inst(random_op(5'(rand_bits(5))));
		end
		end_test("random");

		// dependent chains
		for (int c = 0; c < 4; c++) begin
			prev_rd = 5'(rand_bits(5));
			prev_rd = (prev_rd == '0) ? 5'd2 : prev_rd;
			issue_inst(make_imm_op(3'd0, prev_rd, 5'd0, 12'(rand_bits(12))));
			for (int n = 0; n < 6; n++) begin
				w = chain_op(prev_rd);
				issue_inst(w);
				prev_rd = w.r.rd;
			end
		end
		end_test("chains");

		// x0 as destination, then as source
		issue_inst(make_imm_op(3'd0, 5'd0, 5'd1, 12'h7ff));
		issue_inst(make_reg_op(3'd4, 5'd0, 5'd1, 5'd2));
		issue_inst(make_reg_op(3'd0, 5'd5, 5'd0, 5'd0));
		issue_inst(make_imm_op(3'd2, 5'd6, 5'd0, 12'h123));
		issue_inst(make_reg_op(3'd3, 5'd7, 5'd0, 5'd6));
		end_test("x0");

		for (int n = 0; n < 8; n++) begin
			w = random_op(5'(rand_bits(5)));
			w.r.opcode = other_opcode(3'(rand_bits(3)));
			issue_inst(w);
		end
		for (int n = 0; n < 4; n++) begin
			issue_inst(random_op(5'(rand_bits(5))));
		end
		end_test("unsupported");

		// 20 back to back, chained so the station backs up
		stall_seen       = 1'b0;
		issued_before    = issue_count;
		committed_before = commit_count;
		prev_rd          = 5'd9;
		for (int n = 0; n < 20; n++) begin
			w = chain_op(prev_rd);
			issue_inst(w);
			prev_rd = w.r.rd;
		end
		wait_drain();
		repeat (8) @(negedge clock);
		if (!stall_seen) begin
			$display("issue_stall never rose during the burst");
			error_count++;
		end
		if ((commit_count - committed_before) != (issue_count - issued_before)) begin
			$display("burst committed %0d instructions but issued %0d",
				commit_count - committed_before, issue_count - issued_before);
			error_count++;
		end
		end_test("burst");

		$display("%0d tests, %0d passed, %0d failed, %0d issued, %0d committed",
			tests_run, tests_run - tests_failed, tests_failed, issue_count, commit_count);
		if ((error_count == 0) && (tests_failed == 0)) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

// ==== flist.f ====
core_pkg.sv
issue_decode.sv
alu_station.sv
reorder_buffer.sv
tomasulo_core.sv
tb_tomasulo_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal -f flist.f --top-module tb_tomasulo_core \
	-o tb_sim > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "build failed"
	exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "tests failed" "$LOG"; then
	exit 1
fi
exit 0
